// ==== list.f ====
+incdir+logic
logic/frontend_pkg.sv
logic/fetch_data_if.sv
logic/fetch_request.sv
logic/prefetch_queue.sv
logic/instr_assembly.sv
logic/fetch_frontend.sv
tests/tb_fetch_frontend.sv

// ==== Makefile ====
# Verilator build and run for the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_frontend
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation did not complete"; exit 1; fi
	@echo "Simulation finished cleanly"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/tb_fetch_frontend.sv ====
/*
 * Fetch front end testbench
 * Memory and decode models drive the DUT through a table of jump scenarios
 */
`timescale 1ns/1ps
`include "frontend_defines.svh"

module tb_fetch_frontend
	import frontend_pkg::*;
();

	localparam int              NUM_TESTS    = 6;
	localparam int              JUMP_TIMEOUT = 64;
	// Word address that answers with a bus error
	localparam logic [31:0]     ERR_ADDR     = 32'h0000_0048;

	typedef struct {
		string       name;
		logic        has_jump;
		logic [31:0] target;
		int          count;
		int          stall_pct;
		int          rdy_pct;
	} test_entry_t;

	logic                  clk;
	logic                  rst_n;
	logic [`FE_W_ADDR-1:0] mem_addr;
	logic                  mem_addr_vld;
	logic                  mem_addr_rdy;
	fetch_word_t           mem_data;
	logic                  mem_data_err;
	logic                  mem_data_vld;
	logic [`FE_W_ADDR-1:0] jump_target;
	logic                  jump_target_vld;
	logic                  jump_target_rdy;
	fetch_word_t           cir;
	hw_count_t             cir_vld;
	hw_mask_t              cir_err;
	hw_count_t             cir_use;

	test_entry_t           tests [NUM_TESTS];
	int                    seed;
	string                 cur_test;
	// Decode model state, the byte address of the next instruction
	logic [31:0]           pc;
	int                    consumed;
	// Memory model and bus observation state, updated at each falling edge
	logic                  acc_pend;
	logic [31:0]           acc_addr;
	logic                  hold_seen;
	logic [31:0]           hold_addr;
	logic                  expect_flush;
	logic                  first_req;

	fetch_frontend uut (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.cir             (cir),
		.cir_vld         (cir_vld),
		.cir_err         (cir_err),
		.cir_use         (cir_use)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// Memory contents and helpers

	// Halfword type follows a[1] ^ a[3], so 32-bit instructions also straddle words
	function automatic logic [15:0] mem_hw(input logic [31:0] a);
		logic [13:0] tag;
		tag = a[14:1] ^ a[28:15] ^ {11'd0, a[31:29]} ^ 14'h2d96;
		if (a[1] ^ a[3]) begin
			return {tag, 2'b11};
		end
		return {tag, 1'b0, a[2]};
	endfunction

	function automatic fetch_word_t word_at(input logic [31:0] a);
		fetch_word_t w;
		w.hw[0] = mem_hw({a[31:2], 2'b00});
		w.hw[1] = mem_hw({a[31:2], 2'b10});
		return w;
	endfunction

	function automatic logic is_err_addr(input logic [31:0] a);
		return a[31:2] == ERR_ADDR[31:2];
	endfunction

	function automatic bit chance(input int pct);
		int r;
		r = $random(seed);
		return ((r & 32'h7fff_ffff) % 100) < pct;
	endfunction

	// ----------------------------------------------------------------------
	// Failure reporting and compare tasks

	task stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task check_instr(input string what, input fetch_word_t exp, input fetch_word_t act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act));
		end
	endtask

	task check_count(input string what, input hw_count_t exp, input hw_count_t act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s %s: expected %0d, actual %0d", cur_test, what, exp, act));
		end
	endtask

	task check_err(input string what, input hw_mask_t exp, input hw_mask_t act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act));
		end
	endtask

	task check_flag(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s %s: expected %b, actual %b", cur_test, what, exp, act));
		end
	endtask

	task check_addr(input string what, input logic [`FE_W_ADDR-1:0] exp,
			input logic [`FE_W_ADDR-1:0] act);
		if (exp !== act) begin
			stop_run($sformatf("ERR %s %s: expected %h, actual %h", cur_test, what, exp, act));
		end
	endtask

	// Compare what decode takes with the memory at the model PC, then step the PC
	task check_consumed(input hw_count_t take);
		fetch_word_t exp_i;
		fetch_word_t act_i;
		hw_mask_t    exp_e;
		hw_mask_t    act_e;
		logic [15:0] lo;
		lo = mem_hw(pc);
		if (lo[1:0] == 2'b11) begin
			exp_i.hw[1] = mem_hw(pc + 32'd2);
			exp_i.hw[0] = lo;
			exp_e       = {is_err_addr(pc + 32'd2), is_err_addr(pc)};
		end else begin
			exp_i.word  = {16'h0000, lo};
			exp_e       = {1'b0, is_err_addr(pc)};
		end
		if (take == 2'd2) begin
			act_i = cir;
			act_e = cir_err;
		end else begin
			act_i.word = {16'h0000, cir.hw[0]};
			act_e      = {1'b0, cir_err[0]};
		end
		check_instr($sformatf("instruction at %h", pc), exp_i, act_i);
		check_err($sformatf("error flags at %h", pc), exp_e, act_e);
		pc = pc + ((lo[1:0] == 2'b11) ? 32'd4 : 32'd2);
		consumed++;
	endtask

	// ----------------------------------------------------------------------
	// One clock cycle of memory, jump and decode stimulus

	task run_cycle(input logic jump_req, input logic [31:0] target, input int stall_pct,
			input int rdy_pct, output logic jump_taken);
		hw_count_t take;
		@(posedge clk);
		#1;
		if (expect_flush) begin
			check_count("cir_vld after jump", 2'd0, cir_vld);
			expect_flush = 1'b0;
		end
		// Read data for the address accepted on the previous edge
		mem_data_vld    = acc_pend;
		mem_data        = acc_pend ? word_at(acc_addr) : '0;
		mem_data_err    = acc_pend && is_err_addr(acc_addr);
		mem_addr_rdy    = chance(rdy_pct);
		jump_target_vld = jump_req;
		jump_target     = target;
		// Decode holds off while it waits for its own jump to go through
		take = 2'd0;
		if (!jump_req && !chance(stall_pct) && (cir_vld != 2'd0)) begin
			if (cir.hw[0][1:0] == 2'b11) begin
				take = (cir_vld == 2'd2) ? 2'd2 : 2'd0;
			end else begin
				take = 2'd1;
			end
		end
		if (take != 2'd0) begin
			check_consumed(take);
		end
		cir_use = take;

		@(negedge clk);
		if (first_req) begin
			check_flag("first request valid", 1'b1, mem_addr_vld);
			check_addr("first request address", `FE_RESET_VECTOR, mem_addr);
			first_req = 1'b0;
		end
		// A request refused last cycle must come back unchanged
		if (hold_seen) begin
			check_flag("held request valid", 1'b1, mem_addr_vld);
			check_addr("held request address", hold_addr, mem_addr);
			check_flag("jump ready while held", 1'b0, jump_target_rdy);
		end
		acc_pend   = mem_addr_vld && mem_addr_rdy;
		acc_addr   = mem_addr;
		hold_seen  = mem_addr_vld && !mem_addr_rdy;
		hold_addr  = mem_addr;
		jump_taken = jump_target_vld && jump_target_rdy;
		if (jump_taken) begin
			expect_flush = 1'b1;
		end
	endtask

	// ----------------------------------------------------------------------
	// Scenario table and main sequence

	initial begin
		int   n;
		logic taken;
		rst_n           = 1'b0;
		mem_addr_rdy    = 1'b0;
		mem_data        = '0;
		mem_data_err    = 1'b0;
		mem_data_vld    = 1'b0;
		jump_target     = '0;
		jump_target_vld = 1'b0;
		cir_use         = 2'd0;
		seed            = 36675;
		pc              = `FE_RESET_VECTOR;
		consumed        = 0;
		acc_pend        = 1'b0;
		acc_addr        = '0;
		hold_seen       = 1'b0;
		hold_addr       = '0;
		expect_flush    = 1'b0;
		first_req       = 1'b0;
		cur_test        = "reset";

		// Name, jump, target, instructions, stall percent, ready percent
		tests[0] = '{"reset_start", 1'b0, 32'h0000_0000, 40, 0, 100};
		tests[1] = '{"mixed_widths", 1'b1, 32'h0000_0100, 60, 0, 100};
		tests[2] = '{"hw_jump", 1'b1, 32'h0000_0206, 40, 10, 80};
		tests[3] = '{"stalls", 1'b1, 32'h0000_0302, 150, 40, 50};
		tests[4] = '{"bus_error", 1'b1, 32'h0000_0040, 30, 20, 70};
		tests[5] = '{"hw_jump_error", 1'b1, 32'h0000_004a, 20, 30, 30};

		repeat (5) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Fetch and jumps are both held off for the first cycle out of reset
		@(negedge clk);
		check_flag("request in first cycle", 1'b0, mem_addr_vld);
		check_flag("jump ready in first cycle", 1'b0, jump_target_rdy);
		check_count("cir_vld after reset", 2'd0, cir_vld);
		check_err("cir_err after reset", 2'b00, cir_err);
		first_req = 1'b1;

		for (int t = 0; t < NUM_TESTS; t++) begin
			cur_test = tests[t].name;
			consumed = 0;
			if (tests[t].has_jump) begin
				taken = 1'b0;
				n     = 0;
				while (!taken) begin
					if (n >= JUMP_TIMEOUT) begin
						stop_run($sformatf("Jump in %s was never accepted", cur_test));
					end
					run_cycle(1'b1, tests[t].target, tests[t].stall_pct, tests[t].rdy_pct,
						taken);
					n++;
				end
				pc = tests[t].target;
			end
			n = 0;
			while (consumed < tests[t].count) begin
				if (n >= tests[t].count * 40 + 100) begin
					stop_run($sformatf("Decode in %s ran out of time with %0d of %0d done",
						cur_test, consumed, tests[t].count));
				end
				run_cycle(1'b0, 32'h0000_0000, tests[t].stall_pct, tests[t].rdy_pct, taken);
				n++;
			end
		end

		$display("Test passed");
		$finish;
	end

endmodule

// ==== logic/fetch_frontend.sv ====
/*
 * Instruction fetch front end
 * Word fetch, prefetch queue and CIR assembly for compressed RISC-V code
 */
`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_frontend
	import frontend_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	// Pipelined instruction bus
	output logic [`FE_W_ADDR-1:0] mem_addr,
	output logic                  mem_addr_vld,
	input  logic                  mem_addr_rdy,
	input  fetch_word_t           mem_data,
	input  logic                  mem_data_err,
	input  logic                  mem_data_vld,

	// Redirect from the core
	input  logic [`FE_W_ADDR-1:0] jump_target,
	input  logic                  jump_target_vld,
	output logic                  jump_target_rdy,

	// Decode side
	output fetch_word_t           cir,
	output hw_count_t             cir_vld,
	output hw_mask_t              cir_err,
	input  hw_count_t             cir_use
);

	fetch_data_if fd ();

	// Queue head, or the bus word itself while the queue is empty
	fetch_word_t head_data;
	logic        head_err;
	hw_mask_t    head_hwvld;
	logic        head_vld;

	fetch_request u_fetch_request (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_addr        (mem_addr),
		.mem_addr_vld    (mem_addr_vld),
		.mem_addr_rdy    (mem_addr_rdy),
		.mem_data        (mem_data),
		.mem_data_err    (mem_data_err),
		.mem_data_vld    (mem_data_vld),
		.jump_target     (jump_target),
		.jump_target_vld (jump_target_vld),
		.jump_target_rdy (jump_target_rdy),
		.fd              (fd.fetch)
	);

	prefetch_queue u_prefetch_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.q          (fd.queue),
		.room       (fd.room),
		.head_data  (head_data),
		.head_err   (head_err),
		.head_hwvld (head_hwvld),
		.head_vld   (head_vld)
	);

	instr_assembly u_instr_assembly (
		.clk        (clk),
		.rst_n      (rst_n),
		.fd         (fd.assembly),
		.head_data  (head_data),
		.head_err   (head_err),
		.head_hwvld (head_hwvld),
		.head_vld   (head_vld),
		.cir        (cir),
		.cir_vld    (cir_vld),
		.cir_err    (cir_err),
		.cir_use    (cir_use)
	);

endmodule

// ==== logic/instr_assembly.sv ====
/*
 * Instruction assembly
 * Builds 16-bit and 32-bit instructions into the CIR from fetched halfwords
 */
`timescale 1ns/1ps
`include "frontend_defines.svh"

module instr_assembly
	import frontend_pkg::*;
(
	input  logic           clk,
	input  logic           rst_n,
	fetch_data_if.assembly fd,
	input  fetch_word_t    head_data,
	input  logic           head_err,
	input  hw_mask_t       head_hwvld,
	input  logic           head_vld,
	output fetch_word_t    cir,
	output hw_count_t      cir_vld,
	output hw_mask_t       cir_err,
	input  hw_count_t      cir_use
);

	localparam int HW = `FE_W_HW;

	// Level counts valid halfwords in {hwbuf, cir}, at most three
	logic [1:0]      level;
	logic [1:0]      level_no_fetch;
	logic [1:0]      level_next;
	logic [1:0]      fill;
	logic [HW-1:0]   hwbuf;
	logic [2*HW-1:0] head_aligned;
	logic [3*HW-1:0] data_shifted;
	logic [3*HW-1:0] data_next;
	logic [2:0]      buf_err;
	logic [2:0]      err_shifted;
	logic [2:0]      err_next;
	logic            room;

	// Upper half stands in for the lower one when the lower is invalid
	assign head_aligned = {head_data.hw[1], head_hwvld[0] ? head_data.hw[0] : head_data.hw[1]};

	// ------------------------------------------------------------------
	// Shift out consumed halfwords

	// Slots that get overwritten or are invalid take whatever is cheapest
	always_comb begin
		if (cir_use[1]) begin
			data_shifted = {hwbuf, cir.hw[1], hwbuf};
			err_shifted  = buf_err >> 2;
		end else if (cir_use[0]) begin
			data_shifted = {hwbuf, hwbuf, cir.hw[1]};
			err_shifted  = buf_err >> 1;
		end else begin
			data_shifted = {hwbuf, cir.word};
			err_shifted  = buf_err;
		end
	end

	assign level_no_fetch = level - cir_use;

	// A full word needs two free slots, a half word only one
	assign room    = level_no_fetch <= (&head_hwvld ? 2'd1 : 2'd2);
	assign fd.room = room;

	// ------------------------------------------------------------------
	// Overlay fresh data above what remains

	always_comb begin
		if (!room) begin
			data_next = data_shifted;
			err_next  = err_shifted;
		end else if (level_no_fetch[1]) begin
			data_next = {head_aligned[HW-1:0], data_shifted[2*HW-1:0]};
			err_next  = {head_err, err_shifted[1:0]};
		end else if (level_no_fetch[0]) begin
			data_next = {head_aligned, data_shifted[HW-1:0]};
			err_next  = {{2{head_err}}, err_shifted[0]};
		end else begin
			data_next = {data_shifted[3*HW-1:2*HW], head_aligned};
			err_next  = {err_shifted[2], {2{head_err}}};
		end
	end

	assign fill = (room && head_vld) ? (&head_hwvld ? 2'd2 : 2'd1) : 2'd0;

	// Jump discards everything held here
	assign level_next = fd.flush ? 2'd0 : level_no_fetch + fill;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			level   <= 2'd0;
			cir_vld <= 2'd0;
			buf_err <= 3'b000;
		end else begin
			level   <= level_next;
			// Decode sees at most two halfwords
			cir_vld <= level_next & ~(level_next >> 1);
			buf_err <= err_next;
		end
	end

	always_ff @(posedge clk) begin
		{hwbuf, cir} <= data_next;
	end

	assign cir_err = buf_err[1:0];

endmodule

// ==== logic/prefetch_queue.sv ====
/*
 * Prefetch queue
 * Compacting shift queue of fetched words with a bypass when empty
 */
`timescale 1ns/1ps
`include "frontend_defines.svh"

module prefetch_queue
	import frontend_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	fetch_data_if.queue q,
	input  logic        room,
	output fetch_word_t head_data,
	output logic        head_err,
	output hw_mask_t    head_hwvld,
	output logic        head_vld
);

	localparam int DEPTH = `FE_QUEUE_DEPTH;

	fetch_word_t      ent_data  [DEPTH];
	logic             ent_err   [DEPTH];
	hw_mask_t         ent_hwvld [DEPTH];
	logic [DEPTH-1:0] ent_vld;
	// Contents of the next entry up, the incoming word above the last one
	fetch_word_t      up_data   [DEPTH];
	logic             up_err    [DEPTH];
	hw_mask_t         up_hwvld  [DEPTH];
	logic [DEPTH-1:0] up_vld;
	logic [DEPTH-1:0] dn_vld;
	logic             empty;
	logic             push;
	logic             pop;

	for (genvar i = 0; i < DEPTH; i++) begin : g_ent
		assign ent_vld[i] = |ent_hwvld[i];
		if (i < DEPTH - 1) begin : g_mid
			assign up_data[i]  = ent_data[i+1];
			assign up_err[i]   = ent_err[i+1];
			assign up_hwvld[i] = ent_hwvld[i+1];
			assign up_vld[i]   = ent_vld[i+1];
		end else begin : g_top
			assign up_data[i]  = q.data;
			assign up_err[i]   = q.err;
			assign up_hwvld[i] = q.hwvld;
			assign up_vld[i]   = 1'b0;
		end
		if (i == 0) begin : g_bottom
			assign dn_vld[i] = 1'b1;
		end else begin : g_above
			assign dn_vld[i] = ent_vld[i-1];
		end
	end

	assign empty         = !ent_vld[0];
	assign q.full        = ent_vld[DEPTH-1];
	assign q.almost_full = ent_vld[DEPTH-2];

	// A word that bypasses into the CIR is not written here as well
	assign push = q.vld && !(room && empty);
	assign pop  = room && !empty;

	// Valid masks define occupancy and stay packed towards entry 0
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				ent_hwvld[i] <= '0;
			end
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (q.flush) begin
					ent_hwvld[i] <= '0;
				end else if (pop) begin
					if (up_vld[i]) begin
						ent_hwvld[i] <= up_hwvld[i];
					end else if (ent_vld[i]) begin
						// Last occupied entry refills from the bus, if anything arrived
						ent_hwvld[i] <= push ? q.hwvld : '0;
					end
				end else if (push && !ent_vld[i] && dn_vld[i]) begin
					ent_hwvld[i] <= q.hwvld;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (pop || (push && !ent_vld[i])) begin
				ent_data[i] <= up_vld[i] ? up_data[i] : q.data;
				ent_err[i]  <= up_vld[i] ? up_err[i] : q.err;
			end
		end
	end

	// Empty queue shows the bus word straight to the assembly stage
	assign head_data  = empty ? q.data : ent_data[0];
	assign head_err   = empty ? q.err : ent_err[0];
	assign head_hwvld = empty ? q.hwvld : ent_hwvld[0];
	assign head_vld   = !empty || q.vld;

endmodule

// ==== logic/fetch_request.sv ====
/*
 * Fetch request generation
 * Drives word fetches, accepts jumps and tracks words in flight on the bus
 */
`timescale 1ns/1ps
`include "frontend_defines.svh"

module fetch_request
	import frontend_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,

	output logic [`FE_W_ADDR-1:0] mem_addr,
	output logic                  mem_addr_vld,
	input  logic                  mem_addr_rdy,
	input  fetch_word_t           mem_data,
	input  logic                  mem_data_err,
	input  logic                  mem_data_vld,

	input  logic [`FE_W_ADDR-1:0] jump_target,
	input  logic                  jump_target_vld,
	output logic                  jump_target_rdy,

	fetch_data_if.fetch           fd
);

	localparam int W_ADDR = `FE_W_ADDR;

	// Fetch address runs ahead of the decode PC in word steps
	logic [W_ADDR-1:0] fetch_addr;
	logic              mem_addr_hold;
	logic              reset_holdoff;
	logic              req_vld;
	logic              fetch_stall;
	logic              jump_now;
	logic              addr_take;
	logic [1:0]        pending;
	logic [1:0]        pending_next;
	logic [1:0]        flush_ctr;
	hw_mask_t          aph_hwvld;
	hw_mask_t          data_hwvld;

	// A held request blocks jumps, so the bus address cannot move under it
	// The first cycle after reset also refuses jumps
	assign jump_target_rdy = !mem_addr_hold && !reset_holdoff;
	assign jump_now        = jump_target_vld && jump_target_rdy;
	assign addr_take       = mem_addr_vld && mem_addr_rdy;

	// ------------------------------------------------------------------
	// Address phase

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			fetch_addr <= `FE_RESET_VECTOR;
		end else if (jump_now) begin
			// Step past the target when the request goes straight through
			fetch_addr <= {jump_target[W_ADDR-1:2] + {{(W_ADDR-3){1'b0}}, mem_addr_rdy}, 2'b00};
		end else if (addr_take) begin
			fetch_addr <= fetch_addr + W_ADDR'(4);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			reset_holdoff <= 1'b1;
		end else begin
			reset_holdoff <= 1'b0;
		end
	end

	// Priority: a held request first, then a jump, then sequential fetch
	always_comb begin
		mem_addr = fetch_addr;
		req_vld  = 1'b1;
		if (mem_addr_hold) begin
			mem_addr = fetch_addr;
		end else if (jump_target_vld) begin
			mem_addr = {jump_target[W_ADDR-1:2], 2'b00};
		end else if (fetch_stall) begin
			req_vld = 1'b0;
		end
	end

	assign mem_addr_vld = req_vld && !reset_holdoff;

	// ------------------------------------------------------------------
	// Bus pipeline tracking

	// Count a request when it first appears, not again while it is held
	assign pending_next = pending + {1'b0, mem_addr_vld && !mem_addr_hold}
		- {1'b0, mem_data_vld};

	// Registered counts only, so bus ready never reaches the address phase
	assign fetch_stall = fd.full
		|| (fd.almost_full && (pending != 2'd0))
		|| (pending > 2'd1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mem_addr_hold <= 1'b0;
			pending       <= 2'd0;
			flush_ctr     <= 2'd0;
		end else begin
			mem_addr_hold <= mem_addr_vld && !mem_addr_rdy;
			pending       <= pending_next;
			// Every fetch still out at the jump returns stale data
			if (jump_now) begin
				flush_ctr <= pending - {1'b0, mem_data_vld};
			end else if ((flush_ctr != 2'd0) && mem_data_vld) begin
				flush_ctr <= flush_ctr - 2'd1;
			end
		end
	end

	// Halfword masks follow each request from address phase to data phase
	// A halfword-aligned target drops the lower half of its first word
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			aph_hwvld  <= 2'b11;
			data_hwvld <= 2'b11;
		end else if (jump_now) begin
			if (mem_addr_rdy) begin
				aph_hwvld  <= 2'b11;
				data_hwvld <= {1'b1, !jump_target[1]};
			end else begin
				aph_hwvld <= {1'b1, !jump_target[1]};
			end
		end else if (addr_take) begin
			data_hwvld <= aph_hwvld;
			aph_hwvld  <= 2'b11;
		end
	end

	// ------------------------------------------------------------------
	// Data phase

	assign fd.data  = mem_data;
	assign fd.err   = mem_data_err;
	assign fd.hwvld = data_hwvld;
	// Stale words are dropped here and reach neither queue nor CIR
	assign fd.vld   = mem_data_vld && (flush_ctr == 2'd0);
	assign fd.flush = jump_now;

endmodule

// ==== logic/fetch_data_if.sv ====
/*
 * Fetched data channel
 * Bus data from the fetch controller to the prefetch queue and assembly stage
 */
`timescale 1ns/1ps

interface fetch_data_if
	import frontend_pkg::*;
();

	// Returning bus word and its attributes
	fetch_word_t data;
	logic        err;
	hw_mask_t    hwvld;
	logic        vld;
	// Pulses in the cycle a jump is accepted
	logic        flush;
	// Queue occupancy, fed back to throttle fetch requests
	logic        full;
	logic        almost_full;
	// Assembly stage can absorb a word this cycle
	logic        room;

	modport fetch (output data, err, hwvld, vld, flush, input full, almost_full);
	modport queue (output full, almost_full, input data, err, hwvld, vld, flush);
	modport assembly (output room, input flush);

endinterface

// ==== logic/frontend_pkg.sv ====
/*
 * Fetch front end types
 * Fetched word views and the halfword mask and count types
 */
`include "frontend_defines.svh"

package frontend_pkg;

	// A bus word is read whole or as two instruction halfwords
	// Halfword 0 sits at the lower byte address
	typedef union packed {
		logic [`FE_W_DATA-1:0]            word;
		logic [1:0][`FE_W_HW-1:0]         hw;
	} fetch_word_t;

	// One valid bit per halfword of a fetched word, bit 0 is the lower halfword
	typedef logic [1:0] hw_mask_t;

	// Halfword count in the range 0 to 2
	typedef logic [1:0] hw_count_t;

endpackage

// ==== logic/frontend_defines.svh ====
/*
 * Fetch front end parameters
 * Reset vector, bus widths, instruction halfword width and prefetch queue depth
 */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// First fetch address after reset, must be word aligned
`define FE_RESET_VECTOR 32'h0000_0000

// Bus address and data widths
`define FE_W_ADDR 32
`define FE_W_DATA 32

// Compressed instructions are built from 16-bit halfwords
`define FE_W_HW 16

// Two entries are the minimum that keeps fetch at full rate under decode stalls
`define FE_QUEUE_DEPTH 2

`endif
